// File: bench/clock_gen.sv
`timescale 1ns/10ps

// Free-running bench clock and the power-on reset of the router
module clock_gen (
    output logic clock,
    output logic arst_n
);

    // 40 ns period
    localparam time HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Reset is released on a falling edge, away from the active clock edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// File: bench/sample_router_checker.sv
`timescale 1ns/10ps

// Protocol properties of the router output, bound into every sample_router
module sample_router_checker (
    input logic clock,
    input logic arst_n,
    input logic out_valid,
    input logic overrun
);

    // A collision is only flagged together with the beat that survived it
    overrun_with_valid: assert property (
        @(posedge clock) disable iff (!arst_n) overrun |-> out_valid
    ) else $error("overrun is high while out_valid is low");

    // Both control outputs come from reset flops and must always be known
    control_known: assert property (
        @(posedge clock) disable iff (!arst_n) !$isunknown({out_valid, overrun})
    ) else $error("out_valid or overrun is unknown after reset");

    // Nothing leaves the router while reset is held
    idle_in_reset: assert property (
        @(posedge clock) !arst_n |-> !out_valid
    ) else $error("out_valid is high during reset");

endmodule

bind sample_router sample_router_checker checker_inst (
    .clock     (clock),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .overrun   (overrun)
);

// File: bench/sample_router_tb.sv
`timescale 1ns/10ps

// Random traffic and register rewrites against a cycle-level model of the router
module sample_router_tb;

    localparam int RESET_CYCLES = 8;
    localparam int PHASE1_CYCLES = 200;
    localparam int WRITE_GAP = 25;
    localparam int PHASE2_CYCLES = 2 * sample_router_pkg::CHANNELS * (WRITE_GAP + 1);
    localparam int SHARED_CYCLES = 240;
    localparam int PHASE3_CYCLES = sample_router_pkg::AVG_LENGTH + 1 + SHARED_CYCLES;
    localparam int BURST_CYCLES = 64;
    localparam int DRAIN_CYCLES = 6;
    // Whole run plus fifty cycles of margin
    localparam int CYCLE_LIMIT = RESET_CYCLES + 1 + PHASE1_CYCLES + PHASE2_CYCLES
        + PHASE3_CYCLES + BURST_CYCLES + DRAIN_CYCLES + 50;
    // Cycles from an input beat to its output beat
    localparam int LATENCY = 3;

    logic clock;
    logic arst_n;
    sample_router_pkg::sample_t in_data;
    sample_router_pkg::user_t in_user;
    sample_router_pkg::dest_t in_dest;
    logic in_last;
    logic in_valid;
    logic reg_write;
    sample_router_pkg::reg_addr_t reg_addr;
    sample_router_pkg::dest_t reg_data;
    sample_router_pkg::sample_t out_data;
    sample_router_pkg::user_t out_user;
    sample_router_pkg::dest_t out_dest;
    logic out_last;
    logic out_valid;
    logic overrun;

    // The model keeps the register map and the progress of each channel's group
    sample_router_pkg::dest_t model_sel [sample_router_pkg::CHANNELS];
    sample_router_pkg::dest_t model_tag [sample_router_pkg::CHANNELS];
    int model_count [sample_router_pkg::CHANNELS];
    int model_sum [sample_router_pkg::CHANNELS];

    // Packed as {valid, overrun, data, user, dest, last}
    logic [34:0] expected_queue [$];
    bit checks_enabled;
    int outputs_checked;
    int overruns_seen;
    int cycle_count;
    integer seed;

    clock_gen clocks (
        .clock  (clock),
        .arst_n (arst_n)
    );

    sample_router uut (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_data   (in_data),
        .in_user   (in_user),
        .in_dest   (in_dest),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data),
        .out_data  (out_data),
        .out_user  (out_user),
        .out_dest  (out_dest),
        .out_last  (out_last),
        .out_valid (out_valid),
        .overrun   (overrun)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
        $display("*** FAILED ***");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    // The model restarts from the default map with an empty pipeline
    task automatic reset_model();
        for (int n = 0; n < sample_router_pkg::CHANNELS; n++) begin
            model_sel[n] = sample_router_pkg::dest_t'(n);
            model_tag[n] = sample_router_pkg::dest_t'(sample_router_pkg::DEST_RESET_BASE + n);
            model_count[n] = 0;
            model_sum[n] = 0;
        end
        expected_queue.delete();
        repeat (LATENCY - 1) expected_queue.push_back('0);
        checks_enabled = 1'b0;
    endtask

    // Advances the model by one rising edge of the router
    task automatic step_model();
        logic e_valid;
        logic e_overrun;
        sample_router_pkg::sample_t e_data;
        sample_router_pkg::user_t e_user;
        sample_router_pkg::dest_t e_dest;
        logic e_last;
        int done_count;
        e_valid = 1'b0;
        e_data = '0;
        e_user = '0;
        e_dest = '0;
        e_last = 1'b0;
        done_count = 0;
        for (int n = 0; n < sample_router_pkg::CHANNELS; n++) begin
            if (in_valid && in_dest == model_sel[n]) begin
                model_sum[n] += int'(in_data);
                model_count[n]++;
                if (model_count[n] == sample_router_pkg::AVG_LENGTH) begin
                    done_count++;
                    // Lowest finished channel wins the merge
                    if (!e_valid) begin
                        e_valid = 1'b1;
                        e_data = sample_router_pkg::sample_t'(model_sum[n] /
                                                              sample_router_pkg::AVG_LENGTH);
                        e_user = in_user;
                        e_dest = model_tag[n];
                        e_last = in_last;
                    end
                    model_count[n] = 0;
                    model_sum[n] = 0;
                end
            end
        end
        e_overrun = done_count > 1;
        expected_queue.push_back({e_valid, e_overrun, e_data, e_user, e_dest, e_last});
        // The matching above still used the map from before this edge
        if (reg_write) begin
            if (int'(reg_addr) < sample_router_pkg::CHANNELS) begin
                model_sel[reg_addr] = reg_data;
            end else begin
                model_tag[int'(reg_addr) - sample_router_pkg::CHANNELS] = reg_data;
            end
        end
        checks_enabled = 1'b1;
    endtask

    task automatic check_outputs();
        logic e_valid;
        logic e_overrun;
        sample_router_pkg::sample_t e_data;
        sample_router_pkg::user_t e_user;
        sample_router_pkg::dest_t e_dest;
        logic e_last;
        {e_valid, e_overrun, e_data, e_user, e_dest, e_last} = expected_queue.pop_front();
        assert (out_valid === e_valid) else report_mismatch("out_valid", e_valid, out_valid);
        assert (overrun === e_overrun) else report_mismatch("overrun", e_overrun, overrun);
        if (e_valid) begin
            assert (out_data === e_data) else report_mismatch("out_data", e_data, out_data);
            assert (out_user === e_user) else report_mismatch("out_user", e_user, out_user);
            assert (out_dest === e_dest) else report_mismatch("out_dest", e_dest, out_dest);
            assert (out_last === e_last) else report_mismatch("out_last", e_last, out_last);
            outputs_checked++;
            if (e_overrun) begin
                overruns_seen++;
            end
        end
    endtask

    always @(posedge clock) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            step_model();
        end
    end

    // Outputs settle after the rising edge, so they are compared on the falling one
    always @(negedge clock) begin
        if (checks_enabled) begin
            check_outputs();
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $fatal(1, "Cycle limit reached");
        end
    end

    task automatic next_cycle();
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic drive_random_beat();
        in_valid = 1'($random(seed));
        in_data = sample_router_pkg::sample_t'($random(seed));
        in_user = sample_router_pkg::user_t'($random(seed));
        // Destinations 4 and 5 are unrouted under the reset map
        in_dest = sample_router_pkg::dest_t'({$random(seed)} % 6);
        in_last = 1'($random(seed));
    endtask

    task automatic send_random_beats(input int cycles);
        repeat (cycles) begin
            next_cycle();
            drive_random_beat();
        end
    endtask

    // Traffic keeps flowing in the cycle of the write
    task automatic write_register(input sample_router_pkg::reg_addr_t addr,
                                  input sample_router_pkg::dest_t data);
        next_cycle();
        drive_random_beat();
        reg_write = 1'b1;
        reg_addr = addr;
        reg_data = data;
    endtask

    // Brings channel 1 level with channel 0, then points it at the same selector
    task automatic share_selector();
        next_cycle();
        while (model_count[1] != model_count[0]) begin
            drive_random_beat();
            in_valid = 1'b1;
            in_dest = model_sel[1];
            next_cycle();
        end
        in_valid = 1'b0;
        reg_write = 1'b1;
        reg_addr = 3'd1;
        reg_data = model_sel[0];
    endtask

    task automatic send_burst(input sample_router_pkg::dest_t dest, input int cycles);
        repeat (cycles) begin
            next_cycle();
            drive_random_beat();
            in_valid = 1'b1;
            in_dest = dest;
        end
    endtask

    initial begin
        seed = 13;
        in_data = '0;
        in_user = '0;
        in_dest = '0;
        in_last = 1'b0;
        in_valid = 1'b0;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        @(posedge arst_n);
        send_random_beats(PHASE1_CYCLES);
        // Selectors move to destinations 5 down to 2
        for (int n = 0; n < sample_router_pkg::CHANNELS; n++) begin
            write_register(sample_router_pkg::reg_addr_t'(n), sample_router_pkg::dest_t'(5 - n));
            send_random_beats(WRITE_GAP);
        end
        // Random output destinations whose two low bits hold the channel number
        // Colliding channels therefore always differ in out_dest
        for (int n = 0; n < sample_router_pkg::CHANNELS; n++) begin
            write_register(sample_router_pkg::reg_addr_t'(sample_router_pkg::CHANNELS + n),
                           {6'($random(seed)), 2'(n)});
            send_random_beats(WRITE_GAP);
        end
        share_selector();
        send_random_beats(SHARED_CYCLES);
        // Channel 3 now listens to destination 2
        send_burst(8'd2, BURST_CYCLES);
        next_cycle();
        in_valid = 1'b0;
        repeat (DRAIN_CYCLES) next_cycle();
        if (outputs_checked > 0 && overruns_seen > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("Run ended without averaged outputs or without a collision");
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sample_router.f
source/sample_router_pkg.sv
source/stream_extractor.sv
source/routing_registers.sv
source/decimating_averager.sv
source/stream_combiner.sv
source/sample_router.sv
bench/clock_gen.sv
bench/sample_router_checker.sv
bench/sample_router_tb.sv

// File: source/decimating_averager.sv
`timescale 1ns/10ps

// Turns every AVG_LENGTH valid samples into one averaged sample
// The mean is truncated without rounding
module decimating_averager (
    input  logic                       clock,
    input  logic                       arst_n,
    input  sample_router_pkg::sample_t in_data,
    input  sample_router_pkg::user_t   in_user,
    input  sample_router_pkg::dest_t   in_dest,
    input  logic                       in_last,
    input  logic                       in_valid,
    output sample_router_pkg::sample_t out_data,
    output sample_router_pkg::user_t   out_user,
    output sample_router_pkg::dest_t   out_dest,
    output logic                       out_last,
    output logic                       out_valid
);

    // Number of beats already accumulated in the current group
    logic [sample_router_pkg::AVG_SHIFT-1:0] count;

    // Running sum of the current group without the incoming beat
    logic [sample_router_pkg::SUM_WIDTH-1:0] sum;

    // Sum including the incoming beat
    logic [sample_router_pkg::SUM_WIDTH-1:0] group_sum;

    // High when the incoming valid beat completes a group
    logic group_done;

    // Zero-extend the sample to the accumulator width before adding
    assign group_sum = sum + {{sample_router_pkg::AVG_SHIFT{1'b0}}, in_data};

    assign group_done = in_valid && (int'(count) == sample_router_pkg::AVG_LENGTH - 1);

    // Counter and accumulator only move on valid beats
    // Idle cycles between matches leave the partial group untouched
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            sum   <= '0;
        end else if (in_valid) begin
            if (group_done) begin
                // Start the next group from scratch
                count <= '0;
                sum   <= '0;
            end else begin
                count <= count + 1'b1;
                sum   <= group_sum;
            end
        end
    end

    // Output valid is a one-cycle pulse per completed group
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= group_done;
        end
    end

    // The result beat takes its tag fields from the final beat of the group
    // The next group may already be filling while this one is on the output
    always_ff @(posedge clock) begin
        if (group_done) begin
            // Dropping the low bits divides by AVG_LENGTH
            out_data <= group_sum[sample_router_pkg::SUM_WIDTH-1:sample_router_pkg::AVG_SHIFT];
            out_user <= in_user;
            out_dest <= in_dest;
            out_last <= in_last;
        end
    end

endmodule

// File: source/routing_registers.sv
`timescale 1ns/10ps

// Eight byte-wide routing registers written through a bare strobe
// The lower half holds channel selectors and the upper half output destinations
module routing_registers (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         reg_write,
    input  sample_router_pkg::reg_addr_t reg_addr,
    input  sample_router_pkg::dest_t     reg_data,
    output sample_router_pkg::dest_t     selector_0,
    output sample_router_pkg::dest_t     selector_1,
    output sample_router_pkg::dest_t     selector_2,
    output sample_router_pkg::dest_t     selector_3,
    output sample_router_pkg::dest_t     out_dest_0,
    output sample_router_pkg::dest_t     out_dest_1,
    output sample_router_pkg::dest_t     out_dest_2,
    output sample_router_pkg::dest_t     out_dest_3
);

    // Register file indexed by address with the selectors first
    sample_router_pkg::dest_t map_reg [2 * sample_router_pkg::CHANNELS];

    // One-hot write enable with at most one bit set per cycle
    logic [2 * sample_router_pkg::CHANNELS - 1:0] write_enable;

    // The strobe gates every enable of the address decode
    always_comb begin
        write_enable = '0;
        if (reg_write) begin
            write_enable[reg_addr] = 1'b1;
        end
    end

    // Reset loads the default map and afterwards each register follows its own enable
    // A write becomes visible to the extractors from the next cycle on
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < sample_router_pkg::CHANNELS; n++) begin
                // Channel n listens to destination n
                map_reg[n] <= sample_router_pkg::dest_t'(n);
                // and retags its beats with base plus n
                map_reg[n + sample_router_pkg::CHANNELS] <=
                    sample_router_pkg::dest_t'(sample_router_pkg::DEST_RESET_BASE + n);
            end
        end else begin
            for (int n = 0; n < 2 * sample_router_pkg::CHANNELS; n++) begin
                if (write_enable[n]) begin
                    map_reg[n] <= reg_data;
                end
            end
        end
    end

    // Selectors sit at addresses 0 to 3
    assign selector_0 = map_reg[0];
    assign selector_1 = map_reg[1];
    assign selector_2 = map_reg[2];
    assign selector_3 = map_reg[3];

    // Output destinations sit at addresses 4 to 7
    assign out_dest_0 = map_reg[sample_router_pkg::CHANNELS];
    assign out_dest_1 = map_reg[sample_router_pkg::CHANNELS + 1];
    assign out_dest_2 = map_reg[sample_router_pkg::CHANNELS + 2];
    assign out_dest_3 = map_reg[sample_router_pkg::CHANNELS + 3];

endmodule

// File: source/sample_router.sv
`timescale 1ns/10ps

// Four-channel sample router for a multiplexed ADC stream
// Input beat to averaged output is three cycles: extractor, averager, combiner
module sample_router (
    input  logic                         clock,
    input  logic                         arst_n,
    input  sample_router_pkg::sample_t   in_data,
    input  sample_router_pkg::user_t     in_user,
    input  sample_router_pkg::dest_t     in_dest,
    input  logic                         in_last,
    input  logic                         in_valid,
    input  logic                         reg_write,
    input  sample_router_pkg::reg_addr_t reg_addr,
    input  sample_router_pkg::dest_t     reg_data,
    output sample_router_pkg::sample_t   out_data,
    output sample_router_pkg::user_t     out_user,
    output sample_router_pkg::dest_t     out_dest,
    output logic                         out_last,
    output logic                         out_valid,
    output logic                         overrun
);

    // Per-channel routing configuration
    sample_router_pkg::dest_t selector [sample_router_pkg::CHANNELS];
    sample_router_pkg::dest_t tag_dest [sample_router_pkg::CHANNELS];

    // Extractor to averager streams
    sample_router_pkg::sample_t ext_data  [sample_router_pkg::CHANNELS];
    sample_router_pkg::user_t   ext_user  [sample_router_pkg::CHANNELS];
    sample_router_pkg::dest_t   ext_dest  [sample_router_pkg::CHANNELS];
    logic                       ext_last  [sample_router_pkg::CHANNELS];
    logic                       ext_valid [sample_router_pkg::CHANNELS];

    // Averager to combiner streams
    sample_router_pkg::sample_t avg_data  [sample_router_pkg::CHANNELS];
    sample_router_pkg::user_t   avg_user  [sample_router_pkg::CHANNELS];
    sample_router_pkg::dest_t   avg_dest  [sample_router_pkg::CHANNELS];
    logic                       avg_last  [sample_router_pkg::CHANNELS];
    logic                       avg_valid [sample_router_pkg::CHANNELS];

    routing_registers registers (
        .clock      (clock),
        .arst_n     (arst_n),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .selector_0 (selector[0]),
        .selector_1 (selector[1]),
        .selector_2 (selector[2]),
        .selector_3 (selector[3]),
        .out_dest_0 (tag_dest[0]),
        .out_dest_1 (tag_dest[1]),
        .out_dest_2 (tag_dest[2]),
        .out_dest_3 (tag_dest[3])
    );

    // Every channel sees the full input stream and keeps only its own beats
    for (genvar n = 0; n < sample_router_pkg::CHANNELS; n++) begin : g_channel
        stream_extractor #(
            .registered (1'b1)
        ) extractor (
            .clock        (clock),
            .arst_n       (arst_n),
            .selector     (selector[n]),
            .out_dest     (tag_dest[n]),
            .in_data      (in_data),
            .in_user      (in_user),
            .in_dest      (in_dest),
            .in_last      (in_last),
            .in_valid     (in_valid),
            .out_data     (ext_data[n]),
            .out_user     (ext_user[n]),
            .out_dest_tag (ext_dest[n]),
            .out_last     (ext_last[n]),
            .out_valid    (ext_valid[n])
        );

        decimating_averager averager (
            .clock     (clock),
            .arst_n    (arst_n),
            .in_data   (ext_data[n]),
            .in_user   (ext_user[n]),
            .in_dest   (ext_dest[n]),
            .in_last   (ext_last[n]),
            .in_valid  (ext_valid[n]),
            .out_data  (avg_data[n]),
            .out_user  (avg_user[n]),
            .out_dest  (avg_dest[n]),
            .out_last  (avg_last[n]),
            .out_valid (avg_valid[n])
        );
    end

    // Channel 0 has the highest merge priority
    stream_combiner combiner (
        .clock      (clock),
        .arst_n     (arst_n),
        .ch_data_0  (avg_data[0]),
        .ch_user_0  (avg_user[0]),
        .ch_dest_0  (avg_dest[0]),
        .ch_last_0  (avg_last[0]),
        .ch_valid_0 (avg_valid[0]),
        .ch_data_1  (avg_data[1]),
        .ch_user_1  (avg_user[1]),
        .ch_dest_1  (avg_dest[1]),
        .ch_last_1  (avg_last[1]),
        .ch_valid_1 (avg_valid[1]),
        .ch_data_2  (avg_data[2]),
        .ch_user_2  (avg_user[2]),
        .ch_dest_2  (avg_dest[2]),
        .ch_last_2  (avg_last[2]),
        .ch_valid_2 (avg_valid[2]),
        .ch_data_3  (avg_data[3]),
        .ch_user_3  (avg_user[3]),
        .ch_dest_3  (avg_dest[3]),
        .ch_last_3  (avg_last[3]),
        .ch_valid_3 (avg_valid[3]),
        .out_data   (out_data),
        .out_user   (out_user),
        .out_dest   (out_dest),
        .out_last   (out_last),
        .out_valid  (out_valid),
        .overrun    (overrun)
    );

endmodule

// File: source/sample_router_pkg.sv
// Shared types and constants of the ADC sample router
package sample_router_pkg;

    // One unsigned ADC conversion result
    typedef logic [15:0] sample_t;

    // Free-form tag that travels with each sample and usually names the ADC channel
    typedef logic [7:0] user_t;

    // Destination code on the stream and also the content of every routing register
    typedef logic [7:0] dest_t;

    // Address of one of the eight routing registers
    typedef logic [2:0] reg_addr_t;

    // Number of extractor and averager channels in the router
    localparam int CHANNELS = 4;

    // Averaging length is a power of two so the mean is a plain shift
    localparam int AVG_SHIFT = 2;
    localparam int AVG_LENGTH = 1 << AVG_SHIFT;

    // Wide enough to hold AVG_LENGTH full-scale samples without overflow
    localparam int SUM_WIDTH = $bits(sample_t) + AVG_SHIFT;

    // Channel n comes out of reset retagging its beats with DEST_RESET_BASE + n
    // Its selector resets to n, so destinations 0 to 3 are routed by default
    // Addresses 0 to 3 of the register map are selectors and 4 to 7 output destinations
    localparam int DEST_RESET_BASE = 16;

endpackage

// File: source/stream_combiner.sv
`timescale 1ns/10ps

// Merges the channel streams into one registered output stream
// Lower channel numbers win and colliding beats from higher channels are lost
module stream_combiner (
    input  logic                       clock,
    input  logic                       arst_n,
    input  sample_router_pkg::sample_t ch_data_0,
    input  sample_router_pkg::user_t   ch_user_0,
    input  sample_router_pkg::dest_t   ch_dest_0,
    input  logic                       ch_last_0,
    input  logic                       ch_valid_0,
    input  sample_router_pkg::sample_t ch_data_1,
    input  sample_router_pkg::user_t   ch_user_1,
    input  sample_router_pkg::dest_t   ch_dest_1,
    input  logic                       ch_last_1,
    input  logic                       ch_valid_1,
    input  sample_router_pkg::sample_t ch_data_2,
    input  sample_router_pkg::user_t   ch_user_2,
    input  sample_router_pkg::dest_t   ch_dest_2,
    input  logic                       ch_last_2,
    input  logic                       ch_valid_2,
    input  sample_router_pkg::sample_t ch_data_3,
    input  sample_router_pkg::user_t   ch_user_3,
    input  sample_router_pkg::dest_t   ch_dest_3,
    input  logic                       ch_last_3,
    input  logic                       ch_valid_3,
    output sample_router_pkg::sample_t out_data,
    output sample_router_pkg::user_t   out_user,
    output sample_router_pkg::dest_t   out_dest,
    output logic                       out_last,
    output logic                       out_valid,
    output logic                       overrun
);

    logic [sample_router_pkg::CHANNELS-1:0] ch_valid;

    assign ch_valid = {ch_valid_3, ch_valid_2, ch_valid_1, ch_valid_0};

    // Overrun is registered in the same cycle as the surviving beat
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            out_valid <= |ch_valid;
            overrun   <= $countones(ch_valid) > 1;
        end
    end

    // Priority mux straight into the payload register
    always_ff @(posedge clock) begin
        if (ch_valid_0) begin
            {out_data, out_user, out_dest, out_last} <=
                {ch_data_0, ch_user_0, ch_dest_0, ch_last_0};
        end else if (ch_valid_1) begin
            {out_data, out_user, out_dest, out_last} <=
                {ch_data_1, ch_user_1, ch_dest_1, ch_last_1};
        end else if (ch_valid_2) begin
            {out_data, out_user, out_dest, out_last} <=
                {ch_data_2, ch_user_2, ch_dest_2, ch_last_2};
        end else if (ch_valid_3) begin
            {out_data, out_user, out_dest, out_last} <=
                {ch_data_3, ch_user_3, ch_dest_3, ch_last_3};
        end
    end

endmodule

// File: source/stream_extractor.sv
`timescale 1ns/10ps

// Picks the beats addressed to one channel out of the shared stream
// A matching beat keeps its payload and gets the channel's output destination
module stream_extractor #(
    parameter bit registered = 1'b1
) (
    input  logic                       clock,
    input  logic                       arst_n,
    input  sample_router_pkg::dest_t   selector,
    input  sample_router_pkg::dest_t   out_dest,
    input  sample_router_pkg::sample_t in_data,
    input  sample_router_pkg::user_t   in_user,
    input  sample_router_pkg::dest_t   in_dest,
    input  logic                       in_last,
    input  logic                       in_valid,
    output sample_router_pkg::sample_t out_data,
    output sample_router_pkg::user_t   out_user,
    output sample_router_pkg::dest_t   out_dest_tag,
    output logic                       out_last,
    output logic                       out_valid
);

    logic match;

    // Destination compare is shared by both builds
    assign match = in_dest == selector;

    generate
        if (registered) begin : g_registered
            // Valid is the only control bit and drops on any beat for another channel
            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    out_valid <= 1'b0;
                end else begin
                    out_valid <= in_valid && match;
                end
            end

            // Payload is only loaded by a real matching beat and otherwise holds
            always_ff @(posedge clock) begin
                if (in_valid && match) begin
                    out_data     <= in_data;
                    out_user     <= in_user;
                    out_dest_tag <= out_dest;
                    out_last     <= in_last;
                end
            end
        end else begin : g_combinational
            // Without a match the whole output beat is forced to zero
            always_comb begin
                if (match) begin
                    out_data     = in_data;
                    out_user     = in_user;
                    out_dest_tag = out_dest;
                    out_last     = in_last;
                    out_valid    = in_valid;
                end else begin
                    out_data     = '0;
                    out_user     = '0;
                    out_dest_tag = '0;
                    out_last     = 1'b0;
                    out_valid    = 1'b0;
                end
            end
        end
    endgenerate

endmodule
